// ==== logic/drac_pkg.sv ====
//############################
// shared bus and motor types
// channel count, register offsets
// watchdog and pwm constants
//############################

`default_nettype none

package drac_pkg;

    // sizing
    localparam int NUM_MOTORS    = 4;
    localparam int PWM_BITS      = 8;     // 256 sysclk pwm period
    localparam int WDOG_TICK     = 16;    // sysclk cycles per wdog count
    localparam int WDOG_PRE_BITS = $clog2(WDOG_TICK);
    localparam int WDOG_BITS     = 16;

    // bus types
    typedef logic [15:0]             addr_t;
    typedef logic [31:0]             quad_t;
    typedef logic [3:0]              chan_t;      // 0 board, 1..NUM_MOTORS motors
    typedef logic [3:0]              ofs_t;       // register offset in channel
    typedef logic [3:0]              board_id_t;
    typedef logic [PWM_BITS-1:0]     duty_t;
    typedef logic [NUM_MOTORS-1:0]   mask_t;      // one bit per motor
    typedef logic [WDOG_BITS-1:0]    wdog_t;      // period in ticks

    // address layout: [15:8] zero, [7:4] channel, [3:0] offset
    localparam int ADDR_CHAN_LSB = 4;
    localparam int ADDR_HI_LSB   = ADDR_CHAN_LSB + $bits(chan_t);

    localparam chan_t CHAN_BOARD = 4'd0;

    // board channel offsets
    localparam ofs_t OFS_STATUS   = 4'd0;
    localparam ofs_t OFS_WDOG     = 4'd3;
    // motor channel offsets
    localparam ofs_t OFS_SETPOINT = 4'd0;

    // status word fields
    localparam int STAT_TO_BIT = 4;       // timeout flag, write 1 to clear
    localparam int STAT_EN_LSB = 8;       // motor enable mask

    // block writer states
    typedef enum logic [1:0] {
        RTW_IDLE,
        RTW_HEADER,
        RTW_DATA
    } rtw_state_t;

endpackage

`default_nettype wire

// ==== logic/rt_block_writer.sv ====
//############################
// real-time block writer
// quadlet stream -> per-channel writes
//############################

`timescale 1ns/1ps
`default_nettype none

module rt_block_writer (
    input  wire                   sysclk,
    input  wire                   rst_n,
    input  wire                   blk_wstart,   // start of block
    input  wire                   blk_wen,      // one quadlet
    input  wire drac_pkg::quad_t  blk_wdata,
    output logic                  rt_wen,
    output drac_pkg::chan_t       rt_waddr,     // channel only, no offset
    output drac_pkg::quad_t       rt_wdata
);

    drac_pkg::rtw_state_t state;
    drac_pkg::chan_t      quad_cnt;      // channel for the next quadlet
    logic                 accept;        // quadlet belongs to current block
    logic                 last_quad;

    // header goes to board channel, then motors 1..NUM_MOTORS
    assign accept    = blk_wen && !blk_wstart && (state != drac_pkg::RTW_IDLE);
    assign last_quad = (quad_cnt == drac_pkg::chan_t'(drac_pkg::NUM_MOTORS));

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= drac_pkg::RTW_IDLE;
            quad_cnt <= drac_pkg::CHAN_BOARD;
            rt_wen   <= 1'b0;
        end else begin
            rt_wen <= 1'b0;                          // single-cycle strobe
            if (blk_wstart) begin
                state    <= drac_pkg::RTW_HEADER;    // restart, even mid-block
                quad_cnt <= drac_pkg::CHAN_BOARD;
            end else if (blk_wen) begin
                case (state)
                    drac_pkg::RTW_HEADER: begin
                        rt_wen   <= 1'b1;            // enable mask write
                        quad_cnt <= quad_cnt + 1'b1;
                        state    <= drac_pkg::RTW_DATA;
                    end
                    drac_pkg::RTW_DATA: begin
                        rt_wen   <= 1'b1;            // setpoint write
                        quad_cnt <= quad_cnt + 1'b1;
                        if (last_quad) begin
                            state <= drac_pkg::RTW_IDLE;
                        end
                    end
                    default: begin
                        state <= drac_pkg::RTW_IDLE; // excess quadlets dropped
                    end
                endcase
            end
        end
    end

    // payload, only qualified by rt_wen downstream
    always_ff @(posedge sysclk) begin
        if (accept) begin
            rt_waddr <= quad_cnt;
            rt_wdata <= blk_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/motor_reg_bank.sv ====
//############################
// motor register bank
// setpoints, enable mask, wdog period
// rt/host write arbitration, read path
//############################

`timescale 1ns/1ps
`default_nettype none

module motor_reg_bank (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire drac_pkg::board_id_t   board_id,
    // host register bus
    input  wire                        reg_wen,
    input  wire drac_pkg::addr_t       reg_waddr,
    input  wire drac_pkg::quad_t       reg_wdata,
    input  wire                        reg_ren,
    input  wire drac_pkg::addr_t       reg_raddr,
    output logic                       reg_rvalid,
    output drac_pkg::quad_t            reg_rdata,
    // real-time writes
    input  wire                        rt_wen,
    input  wire drac_pkg::chan_t       rt_waddr,
    input  wire drac_pkg::quad_t       rt_wdata,
    // watchdog
    input  wire                        wdog_timeout,
    output drac_pkg::wdog_t            wdog_period,
    output logic                       wdog_clear,
    // to pwm
    output drac_pkg::duty_t [drac_pkg::NUM_MOTORS-1:0] duty,
    output drac_pkg::mask_t            motor_en
);

    drac_pkg::quad_t setpoint [drac_pkg::NUM_MOTORS];

    drac_pkg::chan_t wchan, rchan;
    drac_pkg::ofs_t  wofs, rofs;
    logic            w_page0, r_page0;   // upper address bits clear
    logic            wr_status, wr_wdog, wr_setpt;
    logic            rt_board;           // rt header write
    logic            to_d, to_rise;
    drac_pkg::quad_t rd_mux;

    // address split
    assign wchan   = reg_waddr[drac_pkg::ADDR_CHAN_LSB +: $bits(drac_pkg::chan_t)];
    assign rchan   = reg_raddr[drac_pkg::ADDR_CHAN_LSB +: $bits(drac_pkg::chan_t)];
    assign wofs    = reg_waddr[$bits(drac_pkg::ofs_t)-1:0];
    assign rofs    = reg_raddr[$bits(drac_pkg::ofs_t)-1:0];
    assign w_page0 = (reg_waddr[$bits(drac_pkg::addr_t)-1:drac_pkg::ADDR_HI_LSB] == '0);
    assign r_page0 = (reg_raddr[$bits(drac_pkg::addr_t)-1:drac_pkg::ADDR_HI_LSB] == '0);

    // host write decode
    assign wr_status = reg_wen && w_page0 && (wchan == drac_pkg::CHAN_BOARD)
                       && (wofs == drac_pkg::OFS_STATUS);
    assign wr_wdog   = reg_wen && w_page0 && (wchan == drac_pkg::CHAN_BOARD)
                       && (wofs == drac_pkg::OFS_WDOG);
    assign wr_setpt  = reg_wen && w_page0 && (wchan != drac_pkg::CHAN_BOARD)
                       && (wofs == drac_pkg::OFS_SETPOINT);
    assign rt_board  = rt_wen && (rt_waddr == drac_pkg::CHAN_BOARD);

    assign wdog_clear = wr_status && reg_wdata[drac_pkg::STAT_TO_BIT];  // write-1-to-clear
    assign to_rise    = wdog_timeout && !to_d;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < drac_pkg::NUM_MOTORS; i++) begin
                setpoint[i] <= '0;
            end
            motor_en    <= '0;
            wdog_period <= '0;
            to_d        <= 1'b0;
        end else begin
            to_d <= wdog_timeout;
            for (int i = 0; i < drac_pkg::NUM_MOTORS; i++) begin
                if (rt_wen && (rt_waddr == drac_pkg::chan_t'(i + 1))) begin
                    setpoint[i] <= rt_wdata;            // rt wins
                end else if (wr_setpt && (wchan == drac_pkg::chan_t'(i + 1))) begin
                    setpoint[i] <= reg_wdata;
                end
            end
            if (to_rise) begin
                motor_en <= '0;                         // drop enables once on timeout
            end else if (rt_board) begin
                motor_en <= drac_pkg::mask_t'(rt_wdata);  // header low bits
            end else if (wr_status) begin
                motor_en <= reg_wdata[drac_pkg::STAT_EN_LSB +: drac_pkg::NUM_MOTORS];
            end
            if (wr_wdog) begin
                wdog_period <= drac_pkg::wdog_t'(reg_wdata);
            end
        end
    end

    // duty is the low bits of each setpoint
    always_comb begin
        for (int i = 0; i < drac_pkg::NUM_MOTORS; i++) begin
            duty[i] = drac_pkg::duty_t'(setpoint[i]);
        end
    end

    // read mux
    always_comb begin
        rd_mux = '0;                                     // unmapped reads 0
        if (r_page0) begin
            if (rchan == drac_pkg::CHAN_BOARD) begin
                case (rofs)
                    drac_pkg::OFS_STATUS: begin
                        rd_mux[$bits(drac_pkg::board_id_t)-1:0] = board_id;
                        rd_mux[drac_pkg::STAT_TO_BIT] = wdog_timeout;
                        rd_mux[drac_pkg::STAT_EN_LSB +: drac_pkg::NUM_MOTORS] = motor_en;
                    end
                    drac_pkg::OFS_WDOG: rd_mux = drac_pkg::quad_t'(wdog_period);
                    default: rd_mux = '0;
                endcase
            end else if (rofs == drac_pkg::OFS_SETPOINT) begin
                for (int i = 0; i < drac_pkg::NUM_MOTORS; i++) begin
                    if (rchan == drac_pkg::chan_t'(i + 1)) begin
                        rd_mux = setpoint[i];            // full 32-bit readback
                    end
                end
            end
        end
    end

    // registered read, valid one cycle after ren
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
            reg_rdata  <= '0;
        end else begin
            reg_rvalid <= reg_ren;
            if (reg_ren) begin
                reg_rdata <= rd_mux;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/wdog_timer.sv ====
//############################
// watchdog timer
// prescaler + tick counter
// sticky timeout flag
//############################

`timescale 1ns/1ps
`default_nettype none

module wdog_timer (
    input  wire                    sysclk,
    input  wire                    rst_n,
    input  wire                    reg_wen,       // any host write
    input  wire                    rt_wen,        // any rt write
    input  wire drac_pkg::wdog_t   wdog_period,   // 0 -> disabled
    input  wire                    wdog_clear,
    output logic                   wdog_timeout
);

    logic [drac_pkg::WDOG_PRE_BITS-1:0] presc;    // sysclk -> tick divider
    drac_pkg::wdog_t                    tick_cnt;
    logic                               restart;
    logic                               armed;
    logic                               tick;
    logic                               expired;

    assign restart = reg_wen || rt_wen;
    assign armed   = (wdog_period != '0);
    assign tick    = (presc == drac_pkg::WDOG_PRE_BITS'(drac_pkg::WDOG_TICK - 1));
    assign expired = armed && !restart && (tick_cnt >= wdog_period);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            presc        <= '0;
            tick_cnt     <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            // counts frozen while disabled or already timed out
            if (restart || !armed || wdog_timeout) begin
                presc    <= '0;
                tick_cnt <= '0;
            end else begin
                presc <= tick ? '0 : presc + 1'b1;
                if (tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            if (wdog_clear) begin
                wdog_timeout <= 1'b0;
            end else if (expired) begin
                wdog_timeout <= 1'b1;           // sticky until cleared
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pwm_gen.sv ====
//############################
// pwm bank
// shared counter, per-motor compare
//############################

`timescale 1ns/1ps
`default_nettype none

module pwm_gen (
    input  wire                    sysclk,
    input  wire                    rst_n,
    input  wire drac_pkg::duty_t [drac_pkg::NUM_MOTORS-1:0] duty,
    input  wire drac_pkg::mask_t   motor_en,
    input  wire                    wdog_timeout,   // forces all outputs low
    output logic [drac_pkg::NUM_MOTORS-1:0] pwm_out
);

    drac_pkg::duty_t                             cnt;       // free running
    drac_pkg::duty_t [drac_pkg::NUM_MOTORS-1:0] duty_lat;  // active duties
    logic                                        wrap;

    assign wrap = (cnt == '1);   // last cycle of period

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cnt      <= '0;
            duty_lat <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            // new duties start with count 0
            if (wrap) begin
                duty_lat <= duty;
            end
        end
    end

    // high for duty cycles out of 256
    always_comb begin
        for (int i = 0; i < drac_pkg::NUM_MOTORS; i++) begin
            pwm_out[i] = motor_en[i] && !wdog_timeout && (cnt < duty_lat[i]);
        end
    end

endmodule

`default_nettype wire

// ==== logic/drac_top.sv ====
//############################
// board top
// bus side -> motor controller side
//############################

`timescale 1ns/1ps
`default_nettype none

module drac_top (
    input  wire                        sysclk,
    input  wire                        rst_n,
    input  wire drac_pkg::board_id_t   board_id,      // static board switch
    // single register access
    input  wire                        reg_wen,
    input  wire drac_pkg::addr_t       reg_waddr,
    input  wire drac_pkg::quad_t       reg_wdata,
    input  wire                        reg_ren,
    input  wire drac_pkg::addr_t       reg_raddr,
    output logic                       reg_rvalid,
    output drac_pkg::quad_t            reg_rdata,
    // real-time block write stream
    input  wire                        blk_wstart,
    input  wire                        blk_wen,
    input  wire drac_pkg::quad_t       blk_wdata,
    // motor side
    output logic [drac_pkg::NUM_MOTORS-1:0] pwm_out,
    output logic                       wdog_timeout
);

    // rt write path
    logic                                        rt_wen;
    drac_pkg::chan_t                             rt_waddr;
    drac_pkg::quad_t                             rt_wdata;
    // watchdog control
    drac_pkg::wdog_t                             wdog_period;
    logic                                        wdog_clear;
    // pwm setup
    drac_pkg::duty_t [drac_pkg::NUM_MOTORS-1:0] duty;
    drac_pkg::mask_t                             motor_en;

    rt_block_writer u_rtw (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .blk_wstart (blk_wstart),
        .blk_wen    (blk_wen),
        .blk_wdata  (blk_wdata),
        .rt_wen     (rt_wen),
        .rt_waddr   (rt_waddr),
        .rt_wdata   (rt_wdata)
    );

    motor_reg_bank u_regs (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .board_id     (board_id),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_ren      (reg_ren),
        .reg_raddr    (reg_raddr),
        .reg_rvalid   (reg_rvalid),
        .reg_rdata    (reg_rdata),
        .rt_wen       (rt_wen),
        .rt_waddr     (rt_waddr),
        .rt_wdata     (rt_wdata),
        .wdog_timeout (wdog_timeout),
        .wdog_period  (wdog_period),
        .wdog_clear   (wdog_clear),
        .duty         (duty),
        .motor_en     (motor_en)
    );

    wdog_timer u_wdog (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .reg_wen      (reg_wen),      // host writes kick the dog too
        .rt_wen       (rt_wen),
        .wdog_period  (wdog_period),
        .wdog_clear   (wdog_clear),
        .wdog_timeout (wdog_timeout)
    );

    pwm_gen u_pwm (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .duty         (duty),
        .motor_en     (motor_en),
        .wdog_timeout (wdog_timeout),
        .pwm_out      (pwm_out)
    );

endmodule

`default_nettype wire

// ==== tb/drac_props.sv ====
//############################
// bound checks on drac_top
// read strobe timing, pwm gating
// output state after reset
//############################

`timescale 1ns/1ps
`default_nettype none

module drac_props (
    input wire                            sysclk,
    input wire                            rst_n,
    input wire                            reg_ren,
    input wire                            reg_rvalid,
    input wire                            wdog_timeout,
    input wire [drac_pkg::NUM_MOTORS-1:0] pwm_out
);

    // valid is ren delayed by one clock, never longer
    rvalid_follows_ren: assert property (@(posedge sysclk) disable iff (!rst_n)
        reg_rvalid == $past(reg_ren))
        else $error("reg_rvalid not one cycle after reg_ren");

    // timed out -> motors off
    pwm_off_on_timeout: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |-> (pwm_out == '0))
        else $error("pwm_out active while wdog_timeout is high");

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge sysclk)
        $rose(rst_n) |-> (!reg_rvalid && !wdog_timeout && (pwm_out == '0)))
        else $error("outputs not zero after reset");

endmodule

bind drac_top drac_props u_props (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .reg_ren      (reg_ren),
    .reg_rvalid   (reg_rvalid),
    .wdog_timeout (wdog_timeout),
    .pwm_out      (pwm_out)
);

`default_nettype wire

// ==== tb/drac_tb.sv ====
//############################
// drac_top testbench
// vector reader, bus/block/pwm/wdog ops
// checks, cycle limit, final report
//############################

`timescale 1ns/1ps
`default_nettype none

module drac_tb;

    logic                            sysclk;
    logic                            rst_n;
    drac_pkg::board_id_t             board_id;
    logic                            reg_wen;
    drac_pkg::addr_t                 reg_waddr;
    drac_pkg::quad_t                 reg_wdata;
    logic                            reg_ren;
    drac_pkg::addr_t                 reg_raddr;
    logic                            reg_rvalid;
    drac_pkg::quad_t                 reg_rdata;
    logic                            blk_wstart;
    logic                            blk_wen;
    drac_pkg::quad_t                 blk_wdata;
    logic [drac_pkg::NUM_MOTORS-1:0] pwm_out;
    logic                            wdog_timeout;

    // one entry per vector line
    logic [7:0]      op_q [$];
    drac_pkg::quad_t addr_q [$];
    drac_pkg::quad_t data_q [$];
    drac_pkg::quad_t exp_q [$];

    int checks = 0;
    int errors = 0;
    int cycles = 0;
    int limit  = 5000;   // raised once the vectors are loaded

    drac_top uut (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;   // 40 ns
    end

    task automatic check_value(input string name, input drac_pkg::quad_t got,
                               input drac_pkg::quad_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*8-1:0]   tok;
        logic [8*160-1:0] rest;
        drac_pkg::quad_t  a;
        drac_pkg::quad_t  d;
        drac_pkg::quad_t  e;
        fd = $fopen("tb/drac_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the vector file tb/drac_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[7:0] == "#") begin
                    n = $fgets(rest, fd);              // comment line, drop the rest
                end else begin
                    n = $fscanf(fd, "%h %h %h", a, d, e);
                    if (n != 3) begin
                        errors++;
                        $display("vector line for op %s is missing fields", tok[7:0]);
                    end
                    op_q.push_back(tok[7:0]);
                    addr_q.push_back(a);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                end
            end
            $fclose(fd);
        end
    endtask

    // every op starts and ends on a falling edge
    task automatic bus_write(input drac_pkg::quad_t addr, input drac_pkg::quad_t data);
        reg_wen   = 1'b1;
        reg_waddr = drac_pkg::addr_t'(addr);
        reg_wdata = data;
        @(negedge sysclk);
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read_expect(input drac_pkg::quad_t addr, input drac_pkg::quad_t exp);
        reg_ren   = 1'b1;
        reg_raddr = drac_pkg::addr_t'(addr);
        @(negedge sysclk);
        reg_ren = 1'b0;
        if (reg_rvalid) begin                       // exactly one cycle after ren
            check_value("reg_rdata", reg_rdata, exp);
        end else begin
            errors++;
            $display("no read response one cycle after the read of address %h", addr);
        end
    endtask

    task automatic block_pulse(input logic start, input drac_pkg::quad_t data);
        blk_wstart = start;
        blk_wen    = !start;
        blk_wdata  = data;
        @(negedge sysclk);
        blk_wstart = 1'b0;
        blk_wen    = 1'b0;
    endtask

    task automatic pwm_high_count(input drac_pkg::quad_t bit_idx, input drac_pkg::quad_t exp);
        int                                   high;
        logic [$clog2(drac_pkg::NUM_MOTORS)-1:0] ch;
        high = 0;
        ch   = bit_idx[$bits(ch)-1:0];
        repeat (2 << drac_pkg::PWM_BITS) @(negedge sysclk);   // two wraps, duties latched
        repeat (1 << drac_pkg::PWM_BITS) begin               // one full period
            @(negedge sysclk);
            if (pwm_out[ch]) begin
                high++;
            end
        end
        check_value("pwm_out", drac_pkg::quad_t'(high), exp);
    endtask

    task automatic watchdog_wait(input drac_pkg::quad_t period);
        int half;
        int waited;
        half   = int'(period) * drac_pkg::WDOG_TICK / 2;
        waited = 0;
        repeat (half) @(negedge sysclk);
        check_value("wdog_timeout", drac_pkg::quad_t'(wdog_timeout), 32'h0);   // too early
        while (!wdog_timeout && waited < half + 20) begin
            @(negedge sysclk);
            waited++;
        end
        checks++;
        if (!wdog_timeout) begin
            errors++;
            $display("watchdog did not time out within %0d cycles", 2 * half + 20);
        end else begin
            // rest of the window, motors held off
            while (waited < half + 20) begin
                @(negedge sysclk);
                waited++;
                check_value("pwm_out", drac_pkg::quad_t'(pwm_out), 32'h0);
            end
            check_value("wdog_timeout", drac_pkg::quad_t'(wdog_timeout), 32'h1);  // sticky
        end
    endtask

    // hang guard
    initial begin
        while (cycles < limit) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("run stopped at the cycle limit of %0d before the vectors were done", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        board_id   = 4'ha;
        reg_wen    = 1'b0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_ren    = 1'b0;
        reg_raddr  = '0;
        blk_wstart = 1'b0;
        blk_wen    = 1'b0;
        blk_wdata  = '0;
        load_vectors();
        limit = 5000 + 300 * op_q.size();
        repeat (16) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;
        @(negedge sysclk);
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": bus_write(addr_q[i], data_q[i]);
                "R": bus_read_expect(addr_q[i], exp_q[i]);
                "B": block_pulse(1'b1, '0);
                "Q": block_pulse(1'b0, data_q[i]);
                "P": pwm_high_count(addr_q[i], exp_q[i]);
                "T": watchdog_wait(data_q[i]);
                default: begin
                    errors++;
                    $display("unknown op %s on vector line %0d", op_q[i], i);
                end
            endcase
        end
        $display("vector lines %0d, checks %0d, errors %0d", op_q.size(), checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== drac_lite.f ====
logic/drac_pkg.sv
logic/rt_block_writer.sv
logic/motor_reg_bank.sv
logic/wdog_timer.sv
logic/pwm_gen.sv
logic/drac_top.sv
tb/drac_props.sv
tb/drac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build drac_tb with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module drac_tb -f drac_lite.f -o drac_sim \
    && ./obj_dir/drac_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// ==== tb/drac_vectors.txt ====
# op addr data expect, all hex; W write, R read and expect, B block start, Q quadlet (data)
# P pwm check (addr = output bit, expect = high cycles), T wait for timeout (data = period)
R 0000 0 0000000a
W 0010 a5a50101 0
W 0020 5a5a0202 0
W 0030 12345603 0
W 0040 fedcba04 0
W 0003 00000123 0
R 0010 0 a5a50101
R 0020 0 5a5a0202
R 0030 0 12345603
R 0040 0 fedcba04
R 0003 0 00000123
R 0001 0 0
R 0060 0 0
R 0105 0 0
W 0003 0 0
W 0000 00000500 0
R 0000 0 0000050a
B 0 0 0
Q 0 00000003 0
Q 0 11111140 0
Q 0 22222280 0
Q 0 333333c0 0
Q 0 44444420 0
Q 0 deadbeef 0
R 0010 0 11111140
R 0020 0 22222280
R 0030 0 333333c0
R 0040 0 44444420
R 0000 0 0000030a
P 0 0 40
P 1 0 80
P 2 0 0
W 0003 00000004 0
T 0 4 0
R 0000 0 0000001a
P 0 0 0
W 0000 00000010 0
R 0000 0 0000000a
